// ==== hdl/dispatch_pkg.sv ====
package dispatch_pkg;

    parameter int xlen  = 32;
    parameter int tag_w = 8;

    // Decode fields of the M extension
    parameter logic [6:0] op_r_type     = 7'b0110011;
    parameter logic [6:0] funct7_muldiv = 7'b0000001;
    parameter logic [2:0] f3_mul        = 3'b000;
    parameter logic [2:0] f3_div        = 3'b100;
    parameter logic [2:0] f3_rem        = 3'b110;

    typedef enum logic [1:0] {
        cls_add = 2'd0,
        cls_mul = 2'd1,
        cls_div = 2'd2
    } unit_class_e;

    typedef struct packed {
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic [3:0] alu_op;
        logic       alu_src1;     // Operand 1 from pc
        logic       alu_src2;     // Operand 2 from imm
        logic       jump;
        logic       branch;
    } ctrl_t;

    // Add station keeps pc and control for branches and memory ops
    typedef struct packed {
        logic [2:0]       func3;
        logic [xlen-1:0]  pc;
        ctrl_t            ctrl;
        logic [tag_w-1:0] dest;
        logic [xlen-1:0]  inst_num;
    } add_payload_t;

    typedef struct packed {
        logic [2:0]       func3;
        logic [tag_w-1:0] dest;
        logic [xlen-1:0]  inst_num;
    } muldiv_payload_t;

endpackage

// ==== hdl/dispatch_steer.sv ====
`timescale 1ns/1ps
module dispatch_steer (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               disp_valid,
    input  logic [6:0]                         disp_opcode,
    input  logic [2:0]                         disp_funct3,
    input  logic [6:0]                         disp_funct7,
    input  logic [dispatch_pkg::xlen-1:0]      disp_op1,
    input  logic [dispatch_pkg::xlen-1:0]      disp_op2,
    input  logic [dispatch_pkg::tag_w-1:0]     disp_op1_tag,
    input  logic [dispatch_pkg::tag_w-1:0]     disp_op2_tag,
    input  logic [1:0]                         disp_op_ready,
    input  logic [dispatch_pkg::xlen-1:0]      disp_imm,
    input  logic [dispatch_pkg::xlen-1:0]      disp_pc,
    input  logic                               disp_mem_to_reg,
    input  logic                               disp_mem_read,
    input  logic                               disp_mem_write,
    input  logic [3:0]                         disp_alu_op,
    input  logic                               disp_alu_src1,
    input  logic                               disp_alu_src2,
    input  logic                               disp_jump,
    input  logic                               disp_branch,
    input  logic [dispatch_pkg::tag_w-1:0]     disp_rd_tag,
    input  logic [dispatch_pkg::xlen-1:0]      disp_inst_num,
    input  logic                               cdb_valid,
    input  logic [dispatch_pkg::tag_w-1:0]     cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0]      cdb_data,
    output logic                               add_wr,
    output logic                               mul_wr,
    output logic                               div_wr,
    output logic [dispatch_pkg::xlen-1:0]      op1,
    output logic [dispatch_pkg::xlen-1:0]      op2,
    output logic                               op1_ok,
    output logic                               op2_ok,
    output logic [dispatch_pkg::tag_w-1:0]     src1_tag,
    output logic [dispatch_pkg::tag_w-1:0]     src2_tag,
    output dispatch_pkg::add_payload_t         add_pay,
    output dispatch_pkg::muldiv_payload_t      md_pay
);

    dispatch_pkg::unit_class_e       cls;
    logic [dispatch_pkg::xlen-1:0]   res_op1;
    logic [dispatch_pkg::xlen-1:0]   res_op2;
    logic                            res_ok1;
    logic                            res_ok2;

    always_comb begin
        cls = dispatch_pkg::cls_add;
        if (disp_opcode == dispatch_pkg::op_r_type &&
            disp_funct7 == dispatch_pkg::funct7_muldiv) begin
            case (disp_funct3)
                dispatch_pkg::f3_mul: cls = dispatch_pkg::cls_mul;
                dispatch_pkg::f3_div,
                dispatch_pkg::f3_rem: cls = dispatch_pkg::cls_div;
                default:              cls = dispatch_pkg::cls_add;   // MULH, DIVU and friends
            endcase
        end
    end

    always_comb begin
        res_op1 = disp_op1;
        res_ok1 = disp_op_ready[0];
        res_op2 = disp_op2;
        res_ok2 = disp_op_ready[1];
        if (disp_alu_src1) begin
            res_op1 = disp_pc;
            res_ok1 = 1'b1;
        end else if (!res_ok1 && cdb_valid && cdb_tag == disp_op1_tag) begin
            res_op1 = cdb_data;                 // Same-cycle bypass
            res_ok1 = 1'b1;
        end
        if (disp_alu_src2) begin
            res_op2 = disp_imm;
            res_ok2 = 1'b1;
        end else if (!res_ok2 && cdb_valid && cdb_tag == disp_op2_tag) begin
            res_op2 = cdb_data;
            res_ok2 = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            add_wr <= 1'b0;
            mul_wr <= 1'b0;
            div_wr <= 1'b0;
        end else begin
            add_wr <= disp_valid && cls == dispatch_pkg::cls_add;
            mul_wr <= disp_valid && cls == dispatch_pkg::cls_mul;
            div_wr <= disp_valid && cls == dispatch_pkg::cls_div;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            op1      <= res_op1;
            op2      <= res_op2;
            op1_ok   <= res_ok1;
            op2_ok   <= res_ok2;
            src1_tag <= disp_op1_tag;
            src2_tag <= disp_op2_tag;
            add_pay  <= '{func3: disp_funct3, pc: disp_pc,
                          ctrl: '{mem_to_reg: disp_mem_to_reg, mem_read: disp_mem_read,
                                  mem_write: disp_mem_write, alu_op: disp_alu_op,
                                  alu_src1: disp_alu_src1, alu_src2: disp_alu_src2,
                                  jump: disp_jump, branch: disp_branch},
                          dest: disp_rd_tag, inst_num: disp_inst_num};
            md_pay   <= '{func3: disp_funct3, dest: disp_rd_tag, inst_num: disp_inst_num};
        end
    end

    a_one_write: assert property (@(posedge clk) disable iff (reset)
        $onehot0({add_wr, mul_wr, div_wr}))
        else $error("more than one station write in a cycle");

endmodule

// ==== hdl/dispatch_top.sv ====
`timescale 1ns/1ps
module dispatch_top #(
    parameter int add_depth = 8,
    parameter int mul_depth = 4,
    parameter int div_depth = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               disp_valid,
    input  logic [6:0]                         disp_opcode,
    input  logic [2:0]                         disp_funct3,
    input  logic [6:0]                         disp_funct7,
    input  logic [dispatch_pkg::xlen-1:0]      disp_op1,
    input  logic [dispatch_pkg::xlen-1:0]      disp_op2,
    input  logic [dispatch_pkg::tag_w-1:0]     disp_op1_tag,
    input  logic [dispatch_pkg::tag_w-1:0]     disp_op2_tag,
    input  logic [1:0]                         disp_op_ready,
    input  logic [dispatch_pkg::xlen-1:0]      disp_imm,
    input  logic [dispatch_pkg::xlen-1:0]      disp_pc,
    input  logic                               disp_mem_to_reg,
    input  logic                               disp_mem_read,
    input  logic                               disp_mem_write,
    input  logic [3:0]                         disp_alu_op,
    input  logic                               disp_alu_src1,
    input  logic                               disp_alu_src2,
    input  logic                               disp_jump,
    input  logic                               disp_branch,
    input  logic [dispatch_pkg::tag_w-1:0]     disp_rd_tag,
    input  logic [dispatch_pkg::xlen-1:0]      disp_inst_num,
    input  logic                               cdb_valid,
    input  logic [dispatch_pkg::tag_w-1:0]     cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0]      cdb_data,
    output logic                               add_full,
    output logic                               mul_full,
    output logic                               div_full,
    output logic                               add_issue,
    output logic [dispatch_pkg::xlen-1:0]      add_op1,
    output logic [dispatch_pkg::xlen-1:0]      add_op2,
    output logic [2:0]                         add_func3,
    output logic [dispatch_pkg::xlen-1:0]      add_pc,
    output logic                               add_mem_to_reg,
    output logic                               add_mem_read,
    output logic                               add_mem_write,
    output logic [3:0]                         add_alu_op,
    output logic                               add_alu_src1,
    output logic                               add_alu_src2,
    output logic                               add_jump,
    output logic                               add_branch,
    output logic [dispatch_pkg::tag_w-1:0]     add_rd_tag,
    output logic [dispatch_pkg::xlen-1:0]      add_inst_num,
    output logic                               mul_issue,
    output logic [dispatch_pkg::xlen-1:0]      mul_op1,
    output logic [dispatch_pkg::xlen-1:0]      mul_op2,
    output logic [2:0]                         mul_func3,
    output logic [dispatch_pkg::tag_w-1:0]     mul_rd_tag,
    output logic [dispatch_pkg::xlen-1:0]      mul_inst_num,
    output logic                               div_issue,
    output logic [dispatch_pkg::xlen-1:0]      div_op1,
    output logic [dispatch_pkg::xlen-1:0]      div_op2,
    output logic [2:0]                         div_func3,
    output logic [dispatch_pkg::tag_w-1:0]     div_rd_tag,
    output logic [dispatch_pkg::xlen-1:0]      div_inst_num
);

    logic                            add_wr;
    logic                            mul_wr;
    logic                            div_wr;
    logic [dispatch_pkg::xlen-1:0]   st_op1;
    logic [dispatch_pkg::xlen-1:0]   st_op2;
    logic                            st_ok1;
    logic                            st_ok2;
    logic [dispatch_pkg::tag_w-1:0]  st_tag1;
    logic [dispatch_pkg::tag_w-1:0]  st_tag2;
    dispatch_pkg::add_payload_t      st_add_pay;
    dispatch_pkg::muldiv_payload_t   st_md_pay;
    dispatch_pkg::add_payload_t      add_iss_pay;
    dispatch_pkg::muldiv_payload_t   mul_iss_pay;
    dispatch_pkg::muldiv_payload_t   div_iss_pay;

    dispatch_steer u_steer (
        .clk(clk), .reset(reset), .disp_valid(disp_valid),
        .disp_opcode(disp_opcode), .disp_funct3(disp_funct3), .disp_funct7(disp_funct7),
        .disp_op1(disp_op1), .disp_op2(disp_op2),
        .disp_op1_tag(disp_op1_tag), .disp_op2_tag(disp_op2_tag),
        .disp_op_ready(disp_op_ready), .disp_imm(disp_imm), .disp_pc(disp_pc),
        .disp_mem_to_reg(disp_mem_to_reg), .disp_mem_read(disp_mem_read),
        .disp_mem_write(disp_mem_write), .disp_alu_op(disp_alu_op),
        .disp_alu_src1(disp_alu_src1), .disp_alu_src2(disp_alu_src2),
        .disp_jump(disp_jump), .disp_branch(disp_branch),
        .disp_rd_tag(disp_rd_tag), .disp_inst_num(disp_inst_num),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .add_wr(add_wr), .mul_wr(mul_wr), .div_wr(div_wr),
        .op1(st_op1), .op2(st_op2), .op1_ok(st_ok1), .op2_ok(st_ok2),
        .src1_tag(st_tag1), .src2_tag(st_tag2),
        .add_pay(st_add_pay), .md_pay(st_md_pay)
    );

    rs_station #(.depth(add_depth), .payload_t(dispatch_pkg::add_payload_t)) u_add_rs (
        .clk(clk), .reset(reset), .wr_en(add_wr),
        .op1(st_op1), .op2(st_op2), .op1_ok(st_ok1), .op2_ok(st_ok2),
        .src1_tag(st_tag1), .src2_tag(st_tag2), .payload(st_add_pay),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .full(add_full), .issue(add_issue),
        .iss_op1(add_op1), .iss_op2(add_op2), .iss_payload(add_iss_pay)
    );

    rs_station #(.depth(mul_depth), .payload_t(dispatch_pkg::muldiv_payload_t)) u_mul_rs (
        .clk(clk), .reset(reset), .wr_en(mul_wr),
        .op1(st_op1), .op2(st_op2), .op1_ok(st_ok1), .op2_ok(st_ok2),
        .src1_tag(st_tag1), .src2_tag(st_tag2), .payload(st_md_pay),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .full(mul_full), .issue(mul_issue),
        .iss_op1(mul_op1), .iss_op2(mul_op2), .iss_payload(mul_iss_pay)
    );

    rs_station #(.depth(div_depth), .payload_t(dispatch_pkg::muldiv_payload_t)) u_div_rs (
        .clk(clk), .reset(reset), .wr_en(div_wr),
        .op1(st_op1), .op2(st_op2), .op1_ok(st_ok1), .op2_ok(st_ok2),
        .src1_tag(st_tag1), .src2_tag(st_tag2), .payload(st_md_pay),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .full(div_full), .issue(div_issue),
        .iss_op1(div_op1), .iss_op2(div_op2), .iss_payload(div_iss_pay)
    );

    // Issue payloads leave the top as loose fields
    assign add_func3      = add_iss_pay.func3;
    assign add_pc         = add_iss_pay.pc;
    assign add_mem_to_reg = add_iss_pay.ctrl.mem_to_reg;
    assign add_mem_read   = add_iss_pay.ctrl.mem_read;
    assign add_mem_write  = add_iss_pay.ctrl.mem_write;
    assign add_alu_op     = add_iss_pay.ctrl.alu_op;
    assign add_alu_src1   = add_iss_pay.ctrl.alu_src1;
    assign add_alu_src2   = add_iss_pay.ctrl.alu_src2;
    assign add_jump       = add_iss_pay.ctrl.jump;
    assign add_branch     = add_iss_pay.ctrl.branch;
    assign add_rd_tag     = add_iss_pay.dest;
    assign add_inst_num   = add_iss_pay.inst_num;
    assign mul_func3      = mul_iss_pay.func3;
    assign mul_rd_tag     = mul_iss_pay.dest;
    assign mul_inst_num   = mul_iss_pay.inst_num;
    assign div_func3      = div_iss_pay.func3;
    assign div_rd_tag     = div_iss_pay.dest;
    assign div_inst_num   = div_iss_pay.inst_num;

endmodule

// ==== hdl/rs_station.sv ====
`timescale 1ns/1ps
module rs_station #(
    parameter int  depth     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_en,
    input  logic [dispatch_pkg::xlen-1:0]      op1,
    input  logic [dispatch_pkg::xlen-1:0]      op2,
    input  logic                               op1_ok,
    input  logic                               op2_ok,
    input  logic [dispatch_pkg::tag_w-1:0]     src1_tag,
    input  logic [dispatch_pkg::tag_w-1:0]     src2_tag,
    input  payload_t                           payload,
    input  logic                               cdb_valid,
    input  logic [dispatch_pkg::tag_w-1:0]     cdb_tag,
    input  logic [dispatch_pkg::xlen-1:0]      cdb_data,
    output logic                               full,
    output logic                               issue,
    output logic [dispatch_pkg::xlen-1:0]      iss_op1,
    output logic [dispatch_pkg::xlen-1:0]      iss_op2,
    output payload_t                           iss_payload
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    logic [depth-1:0]               busy;
    logic [depth-1:0]               rdy1;
    logic [depth-1:0]               rdy2;
    logic [depth-1:0]               wake1;
    logic [depth-1:0]               wake2;
    logic [dispatch_pkg::xlen-1:0]  val1 [depth];
    logic [dispatch_pkg::xlen-1:0]  val2 [depth];
    logic [dispatch_pkg::tag_w-1:0] tag1 [depth];
    logic [dispatch_pkg::tag_w-1:0] tag2 [depth];
    payload_t                       pay  [depth];

    logic [idx_w-1:0]               wr_idx;
    logic [idx_w-1:0]               iss_idx;
    logic                           free_found;
    logic                           iss_found;
    logic                           in_hit1;
    logic                           in_hit2;
    logic                           do_wr;

    assign full  = &busy;
    assign do_wr = wr_en && free_found;

    // CDB can land while the entry sits in the steer register
    assign in_hit1 = !op1_ok && cdb_valid && cdb_tag == src1_tag;
    assign in_hit2 = !op2_ok && cdb_valid && cdb_tag == src2_tag;

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            wake1[i] = busy[i] && !rdy1[i] && cdb_valid && tag1[i] == cdb_tag;
            wake2[i] = busy[i] && !rdy2[i] && cdb_valid && tag2[i] == cdb_tag;
        end
    end

    // Downward scan leaves the lowest index
    always_comb begin
        free_found = 1'b0;
        wr_idx     = '0;
        iss_found  = 1'b0;
        iss_idx    = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                wr_idx     = idx_w'(i);
            end
            if (busy[i] && rdy1[i] && rdy2[i]) begin
                iss_found = 1'b1;
                iss_idx   = idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= '0;
            rdy1  <= '0;
            rdy2  <= '0;
            issue <= 1'b0;
        end else begin
            issue <= iss_found;
            rdy1  <= rdy1 | wake1;
            rdy2  <= rdy2 | wake2;
            if (iss_found) begin
                busy[iss_idx] <= 1'b0;
            end
            if (do_wr) begin
                busy[wr_idx] <= 1'b1;
                rdy1[wr_idx] <= op1_ok | in_hit1;
                rdy2[wr_idx] <= op2_ok | in_hit2;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            if (wake1[i]) begin
                val1[i] <= cdb_data;
            end
            if (wake2[i]) begin
                val2[i] <= cdb_data;
            end
        end
        if (do_wr) begin
            val1[wr_idx] <= in_hit1 ? cdb_data : op1;
            val2[wr_idx] <= in_hit2 ? cdb_data : op2;
            tag1[wr_idx] <= src1_tag;
            tag2[wr_idx] <= src2_tag;
            pay[wr_idx]  <= payload;
        end
        if (iss_found) begin
            iss_op1     <= val1[iss_idx];
            iss_op2     <= val2[iss_idx];
            iss_payload <= pay[iss_idx];
        end
    end

    a_no_wr_full: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !full)
        else $error("dispatch into a full reservation station");

    // Back-to-back issues need a second entry, already held or just written
    a_no_ghost_issue: assert property (@(posedge clk) disable iff (reset)
        issue && $past(issue) |-> $past($countones(busy) > 1, 2) || $past(do_wr, 2))
        else $error("issue from an empty reservation station");

endmodule

// ==== sim.f ====
+incdir+verif
hdl/dispatch_pkg.sv
hdl/dispatch_steer.sv
hdl/rs_station.sv
hdl/dispatch_top.sv
verif/dispatch_tb.sv

// ==== verif/dispatch_ref.svh ====
// Expected issue record, indexed by inst_num
dispatch_pkg::unit_class_e exp_cls  [max_inst];
logic [31:0]               exp_op1  [max_inst];
logic [31:0]               exp_op2  [max_inst];
logic [2:0]                exp_f3   [max_inst];
logic [31:0]               exp_pc   [max_inst];
logic [10:0]               exp_ctrl [max_inst];
logic [7:0]                exp_rd   [max_inst];
bit                        sent     [max_inst];
bit                        seen     [max_inst];
logic [31:0]               cdb_plan [256];      // Data that every broadcast of a tag carries

// Only MUL, DIV and REM of the M extension leave the add class
function automatic dispatch_pkg::unit_class_e ref_class(logic [6:0] opcode, logic [2:0] f3,
                                                       logic [6:0] f7);
    if (opcode == dispatch_pkg::op_r_type && f7 == dispatch_pkg::funct7_muldiv) begin
        if (f3 == dispatch_pkg::f3_mul) begin
            return dispatch_pkg::cls_mul;
        end
        if (f3 == dispatch_pkg::f3_div || f3 == dispatch_pkg::f3_rem) begin
            return dispatch_pkg::cls_div;
        end
    end
    return dispatch_pkg::cls_add;                // MULH, DIVU, REMU and plain ops
endfunction

function automatic logic [31:0] ref_resolve(logic sub, logic [31:0] sub_val, logic ok,
                                            logic [31:0] val, logic [7:0] tag);
    if (sub) begin
        return sub_val;                          // pc or imm, always ready
    end
    if (ok) begin
        return val;
    end
    return cdb_plan[tag];                        // Filled by a broadcast of its tag
endfunction

task automatic check_equal(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
        abort_run($sformatf("Mismatch in %s, %s: expected %0h, actual %0h",
                            test_name, name, expected, actual));
    end
endtask

// ==== verif/dispatch_tb.sv ====
`timescale 1ns/1ps
module dispatch_tb;

    localparam int max_inst   = 512;
    localparam int add_depth  = 8;
    localparam int mul_depth  = 4;
    localparam int div_depth  = 4;
    localparam int num_random = 300;

    logic        clk;
    logic        reset;
    logic        disp_valid;
    logic [6:0]  disp_opcode, disp_funct7;
    logic [2:0]  disp_funct3;
    logic [31:0] disp_op1, disp_op2, disp_imm, disp_pc, disp_inst_num;
    logic [7:0]  disp_op1_tag, disp_op2_tag, disp_rd_tag;
    logic [1:0]  disp_op_ready;
    logic [3:0]  disp_alu_op;
    logic        disp_mem_to_reg, disp_mem_read, disp_mem_write;
    logic        disp_alu_src1, disp_alu_src2, disp_jump, disp_branch;
    logic        cdb_valid;
    logic [7:0]  cdb_tag;
    logic [31:0] cdb_data;
    logic        add_full, mul_full, div_full;
    logic        add_issue, mul_issue, div_issue;
    logic [31:0] add_op1, add_op2, add_pc, add_inst_num;
    logic [31:0] mul_op1, mul_op2, mul_inst_num, div_op1, div_op2, div_inst_num;
    logic [2:0]  add_func3, mul_func3, div_func3;
    logic [7:0]  add_rd_tag, mul_rd_tag, div_rd_tag;
    logic [3:0]  add_alu_op;
    logic        add_mem_to_reg, add_mem_read, add_mem_write;
    logic        add_alu_src1, add_alu_src2, add_jump, add_branch;
    logic [2:0]  full_vec;                       // Indexed by class

    string       test_name;
    int          n_sent;
    int          n_issued;
    int          cycle_cnt;
    int          sent_cls   [3];
    int          issued_cls [3];
    int          depth_of   [3] = '{add_depth, mul_depth, div_depth};
    bit          run_done;
    logic [7:0]  pending [$];                    // Tags that an operand still waits on

    task automatic abort_run(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

`include "dispatch_ref.svh"

    dispatch_top #(
        .add_depth(add_depth),
        .mul_depth(mul_depth),
        .div_depth(div_depth)
    ) UUT (.*);

    assign full_vec = {div_full, mul_full, add_full};

    always #10 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        cdb_valid  = 1'b0;
    endtask

    task automatic send_inst(logic [6:0] opcode, logic [2:0] f3, logic [6:0] f7,
                             logic [1:0] ready, logic src1, logic src2);
        int n;
        n = n_sent;
        disp_valid    = 1'b1;
        disp_opcode   = opcode;
        disp_funct3   = f3;
        disp_funct7   = f7;
        disp_op1      = $urandom;
        disp_op2      = $urandom;
        disp_op1_tag  = 8'($urandom);
        disp_op2_tag  = 8'($urandom);
        disp_op_ready = ready;
        disp_imm      = $urandom;
        disp_pc       = $urandom;
        {disp_mem_to_reg, disp_mem_read, disp_mem_write, disp_alu_op, disp_jump,
         disp_branch} = 9'($urandom);
        disp_alu_src1 = src1;
        disp_alu_src2 = src2;
        disp_rd_tag   = 8'($urandom);
        disp_inst_num = n;
        exp_cls[n]  = ref_class(opcode, f3, f7);
        exp_op1[n]  = ref_resolve(src1, disp_pc, ready[0], disp_op1, disp_op1_tag);
        exp_op2[n]  = ref_resolve(src2, disp_imm, ready[1], disp_op2, disp_op2_tag);
        exp_f3[n]   = f3;
        exp_pc[n]   = disp_pc;
        exp_ctrl[n] = {disp_mem_to_reg, disp_mem_read, disp_mem_write, disp_alu_op,
                       src1, src2, disp_jump, disp_branch};
        exp_rd[n]   = disp_rd_tag;
        sent[n]     = 1'b1;
        if (!src1 && !ready[0]) begin
            pending.push_back(disp_op1_tag);
        end
        if (!src2 && !ready[1]) begin
            pending.push_back(disp_op2_tag);
        end
        sent_cls[exp_cls[n]]++;
        n_sent++;
    endtask

    task automatic broadcast(int idx);
        cdb_valid = 1'b1;
        cdb_tag   = pending[idx];
        cdb_data  = cdb_plan[pending[idx]];
        pending.delete(idx);
    endtask

    task automatic random_cdb();
        if (pending.size() > 0 && $urandom_range(1, 0) == 1) begin
            broadcast($urandom_range(pending.size() - 1, 0));   // Out of order
        end
    endtask

    task automatic wait_all_issued();
        while (n_issued < n_sent) begin
            next_cycle();
            if (pending.size() > 0) begin
                broadcast(0);
            end
        end
    endtask

    function automatic bit has_space(dispatch_pkg::unit_class_e c);
        return sent_cls[c] - issued_cls[c] < depth_of[c];
    endfunction

    task automatic pick_inst(output logic [6:0] op, output logic [2:0] f3,
                             output logic [6:0] f7);
        int kind;
        kind = $urandom_range(5, 0);
        op   = dispatch_pkg::op_r_type;
        f7   = dispatch_pkg::funct7_muldiv;
        f3   = 3'($urandom);
        case (kind)
            0: f3 = dispatch_pkg::f3_mul;
            1: f3 = dispatch_pkg::f3_div;
            2: f3 = dispatch_pkg::f3_rem;
            3: f7 = 7'($urandom);
            4: op = 7'($urandom);
            default: ;                           // Random M-extension funct3
        endcase
    endtask

    task automatic check_issue(string unit, dispatch_pkg::unit_class_e cls,
                               logic [31:0] op1, logic [31:0] op2, logic [2:0] f3,
                               logic [7:0] rd, logic [31:0] num, logic [31:0] pc,
                               logic [10:0] ctrl);
        if (run_done) begin
            abort_run($sformatf("The %s unit issued after the end of the run", unit));
        end
        if (num >= max_inst || !sent[num]) begin
            abort_run($sformatf("The %s unit issued inst_num %0d that was never dispatched",
                                unit, num));
        end
        if (seen[num]) begin
            abort_run($sformatf("The %s unit issued inst_num %0d a second time", unit, num));
        end
        check_equal("class", exp_cls[num], cls);
        check_equal("op1", exp_op1[num], op1);
        check_equal("op2", exp_op2[num], op2);
        check_equal("func3", exp_f3[num], f3);
        check_equal("rd_tag", exp_rd[num], rd);
        if (cls == dispatch_pkg::cls_add) begin
            check_equal("pc", exp_pc[num], pc);
            check_equal("ctrl", exp_ctrl[num], ctrl);
        end
        seen[num] = 1'b1;
        issued_cls[cls]++;
        n_issued++;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (add_issue) begin
                check_issue("add", dispatch_pkg::cls_add, add_op1, add_op2, add_func3,
                            add_rd_tag, add_inst_num, add_pc,
                            {add_mem_to_reg, add_mem_read, add_mem_write, add_alu_op,
                             add_alu_src1, add_alu_src2, add_jump, add_branch});
            end
            if (mul_issue) begin
                check_issue("multiply", dispatch_pkg::cls_mul, mul_op1, mul_op2, mul_func3,
                            mul_rd_tag, mul_inst_num, 32'd0, 11'd0);
            end
            if (div_issue) begin
                check_issue("divide", dispatch_pkg::cls_div, div_op1, div_op2, div_func3,
                            div_rd_tag, div_inst_num, 32'd0, 11'd0);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 40 * n_sent + 200) begin
            abort_run("Timeout: not every dispatched instruction issued in time");
        end
    end

    initial begin
        logic [1:0] rdy;
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        void'($urandom(17));
        clk        = 1'b0;
        reset      = 1'b1;
        disp_valid = 1'b0;
        cdb_valid  = 1'b0;
        cdb_tag    = '0;
        cdb_data   = '0;
        {disp_opcode, disp_funct3, disp_funct7, disp_op1, disp_op2, disp_op1_tag,
         disp_op2_tag, disp_op_ready, disp_imm, disp_pc, disp_mem_to_reg, disp_mem_read,
         disp_mem_write, disp_alu_op, disp_alu_src1, disp_alu_src2, disp_jump, disp_branch,
         disp_rd_tag, disp_inst_num} = '0;
        for (int t = 0; t < 256; t++) begin
            cdb_plan[t] = $urandom;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "class_routing";
        for (int k = 0; k < 8; k++) begin
            next_cycle();
            case (k)
                0: send_inst(dispatch_pkg::op_r_type, 3'b000, 7'b0000001, 2'b11, 0, 0);
                1: send_inst(dispatch_pkg::op_r_type, 3'b100, 7'b0000001, 2'b11, 0, 0);
                2: send_inst(dispatch_pkg::op_r_type, 3'b110, 7'b0000001, 2'b11, 0, 0);
                3: send_inst(dispatch_pkg::op_r_type, 3'b001, 7'b0000001, 2'b11, 0, 0);
                4: send_inst(dispatch_pkg::op_r_type, 3'b101, 7'b0000001, 2'b11, 0, 0);
                5: send_inst(dispatch_pkg::op_r_type, 3'b000, 7'b0000000, 2'b11, 0, 0);
                6: send_inst(dispatch_pkg::op_r_type, 3'b000, 7'b0100000, 2'b11, 0, 0);
                default: send_inst(7'b0000011, 3'b000, 7'b0000001, 2'b11, 0, 0);  // Load
            endcase
        end
        wait_all_issued();

        test_name = "ready_operands";
        for (int k = 0; k < 8; k++) begin
            next_cycle();
            rdy = (k < 4) ? 2'b11 : (k == 6) ? 2'b10 : (k == 7) ? 2'b01 : 2'b00;
            send_inst(dispatch_pkg::op_r_type, 3'(2 * (k % 4)), dispatch_pkg::funct7_muldiv,
                      rdy, k >= 4 && k != 7, k >= 4 && k != 6);
        end
        wait_all_issued();

        test_name = "cdb_wakeup";
        pending.delete();
        for (int k = 0; k < 6; k++) begin
            next_cycle();
            send_inst(dispatch_pkg::op_r_type, 3'(2 * (k % 4)), dispatch_pkg::funct7_muldiv,
                      2'(k % 3), 1'b0, 1'b0);
            if (k >= 3) begin
                broadcast(pending.size() - 1);   // Bypass in the dispatch cycle
            end
        end
        repeat (3) next_cycle();
        wait_all_issued();

        test_name = "full_flags";
        for (int c = 0; c < 3; c++) begin
            pending.delete();
            for (int k = 0; k < depth_of[c]; k++) begin
                next_cycle();
                case (c)
                    0: send_inst(dispatch_pkg::op_r_type, 3'b000, 7'b0000000,
                                 2'b00, 1'b0, 1'b0);
                    1: send_inst(dispatch_pkg::op_r_type, dispatch_pkg::f3_mul,
                                 dispatch_pkg::funct7_muldiv, 2'b00, 1'b0, 1'b0);
                    default: send_inst(dispatch_pkg::op_r_type, dispatch_pkg::f3_div,
                                       dispatch_pkg::funct7_muldiv, 2'b00, 1'b0, 1'b0);
                endcase
            end
            repeat (2) next_cycle();
            check_equal($sformatf("full flag of class %0d", c), 64'd1, full_vec[c]);
            broadcast(0);                        // Both tags of the oldest entry
            next_cycle();
            broadcast(0);
            while (issued_cls[c] == sent_cls[c] - depth_of[c]) begin
                next_cycle();
            end
            check_equal($sformatf("full flag of class %0d", c), 64'd0, full_vec[c]);
            wait_all_issued();
        end

        test_name = "random_mix";
        for (int k = 0; k < num_random; k++) begin
            next_cycle();
            pick_inst(op, f3, f7);
            while (!has_space(ref_class(op, f3, f7))) begin
                random_cdb();
                next_cycle();
            end
            send_inst(op, f3, f7, 2'($urandom), 1'($urandom), 1'($urandom));
            random_cdb();
        end
        wait_all_issued();

        run_done = 1'b1;
        repeat (10) next_cycle();
        if (n_issued == n_sent) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("The run ended with instructions that never issued");
        end
    end

endmodule
